//--- Makefile
# Verilator build and run of the sniffer testbench

VERILATOR ?= verilator
TOP       ?= tb_ccip_sniffer
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ccip_sniffer.sv
//##########################################################################
// Observe-only protocol checker, error_code lags the offending beat by one
//##########################################################################
`timescale 1ns/100ps

module ccip_sniffer import sniff_pkg::*; #(
   parameter int TID_WIDTH      = 4,
   parameter int TIMEOUT_CYCLES = 64
) (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  logic                  c0_realfull,
   input  logic                  c1_realfull,
   input  logic                  c0_valid,
   input  req_type_t             c0_req_type,
   input  cl_len_t               c0_cl_len,
   input  logic [ADDR_WIDTH-1:0] c0_address,
   input  logic                  c1_valid,
   input  req_type_t             c1_req_type,
   input  cl_len_t               c1_cl_len,
   input  logic [ADDR_WIDTH-1:0] c1_address,
   input  vc_sel_t               c1_vc_sel,
   input  logic                  c1_sop,
   input  logic                  c2_mmio_rd_valid,
   input  logic [TID_WIDTH-1:0]  c2_tid,
   input  logic                  rx_mmio_rd_valid,
   input  logic [TID_WIDTH-1:0]  rx_mmio_tid,
   output sniff_vec_t            error_code
);

   localparam int NUM_TID = 2**TID_WIDTH;

   sniff_vec_t tx_errors;
   sniff_vec_t mcl_errors;
   sniff_vec_t mmio_errors;

   sniff_c1_if c1_bus ();
   mmio_track_if #(.TID_WIDTH(TID_WIDTH)) trk_bus ();

   // Channel 1 header into the shared bundle
   assign c1_bus.valid    = c1_valid;
   assign c1_bus.req_type = c1_req_type;
   assign c1_bus.cl_len   = c1_cl_len;
   assign c1_bus.address  = c1_address;
   assign c1_bus.vc_sel   = c1_vc_sel;
   assign c1_bus.sop      = c1_sop;

   sniff_tx_checker tx_chk_i (
      .c0_valid, .c0_req_type, .c0_cl_len, .c0_address, .c0_realfull,
      .c1_realfull, .soft_reset, .c2_mmio_rd_valid,
      .c1(c1_bus.mon), .errors(tx_errors)
   );

   sniff_mcl_fsm mcl_i (.clk, .ase_reset, .c1(c1_bus.mon), .errors(mcl_errors));

   sniff_mmio_dispatch #(.TID_WIDTH(TID_WIDTH)) disp_i (
      .rx_mmio_rd_valid, .rx_mmio_tid, .c2_mmio_rd_valid, .c2_tid,
      .trk(trk_bus.dispatch), .errors(mmio_errors)
   );

   // One tracker per MMIO TID
   for (genvar i = 0; i < NUM_TID; i++) begin : gen_trk
      sniff_mmio_tracker #(
         .TID_WIDTH(TID_WIDTH), .TIMEOUT_CYCLES(TIMEOUT_CYCLES), .INDEX(i)
      ) trk_i (.clk, .ase_reset, .trk(trk_bus.track));
   end

   sniff_error_collect #(.TID_WIDTH(TID_WIDTH)) coll_i (
      .clk, .ase_reset, .tx_errors, .mcl_errors, .mmio_errors,
      .trk(trk_bus.drain), .error_code
   );

endmodule

//--- mmio_track_if.sv
//##########################################################################
// Per-TID MMIO tracking bits, one bit per TID in each array
//##########################################################################
`timescale 1ns/100ps

interface mmio_track_if #(
   parameter int TID_WIDTH = 4
) ();

   localparam int NUM_TID = 2**TID_WIDTH;

   // One-hot request and response hits
   logic [NUM_TID-1:0] req_hit;
   logic [NUM_TID-1:0] rsp_hit;
   // Tracker state, one bit per tracker instance
   logic [NUM_TID-1:0] active;
   logic [NUM_TID-1:0] timeout;

   modport dispatch (
      output req_hit,
      output rsp_hit,
      input  active
   );

   modport track (
      input  req_hit,
      input  rsp_hit,
      output active,
      output timeout
   );

   modport drain (
      input timeout
   );

endinterface

//--- sniff_c1_if.sv
//##########################################################################
// Channel 1 request header as seen by the checkers, read-only
//##########################################################################
`timescale 1ns/100ps

interface sniff_c1_if import sniff_pkg::*; ();

   // Header fields of one channel 1 beat
   logic                  valid;
   req_type_t             req_type;
   cl_len_t               cl_len;
   logic [ADDR_WIDTH-1:0] address;
   vc_sel_t               vc_sel;
   logic                  sop;

   // Checkers only watch
   modport mon (
      input valid,
      input req_type,
      input cl_len,
      input address,
      input vc_sel,
      input sop
   );

endinterface

//--- sniff_error_collect.sv
//##########################################################################
// One register stage; every bit is a single-cycle pulse per violation
//##########################################################################
`timescale 1ns/100ps

module sniff_error_collect import sniff_pkg::*; #(
   parameter int TID_WIDTH = 4
) (
   input  logic       clk,
   input  logic       ase_reset,
   input  sniff_vec_t tx_errors,
   input  sniff_vec_t mcl_errors,
   input  sniff_vec_t mmio_errors,
   mmio_track_if.drain trk,
   output sniff_vec_t error_code
);

   localparam int NUM_TID = 2**TID_WIDTH;

   sniff_vec_t merged;

   always_comb begin
      // Sources own disjoint bits
      merged = tx_errors | mcl_errors | mmio_errors;
      // Any tracker timing out
      merged[MMIO_RDRSP_TIMEOUT] = merged[MMIO_RDRSP_TIMEOUT] |
                                   (|trk.timeout[NUM_TID-1:0]);
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         error_code <= '0;
      end else begin
         error_code <= merged;
      end
   end

endmodule

//--- sniff_mcl_fsm.sv
//##########################################################################
// Tracks channel 1 multi-line bursts; only 2- and 4-line SOP writes start
// one, fences are transparent outside a burst, illegal types are ignored
//##########################################################################
`timescale 1ns/100ps

module sniff_mcl_fsm import sniff_pkg::*; (
   input  logic       clk,
   input  logic       ase_reset,
   sniff_c1_if.mon    c1,
   output sniff_vec_t errors
);

   // One-hot with one state per expected beat
   typedef enum logic [3:0] {
      ST_IDLE  = 4'b0001,
      ST_BEAT1 = 4'b0010,
      ST_BEAT2 = 4'b0100,
      ST_BEAT3 = 4'b1000
   } mcl_state_t;

   mcl_state_t state;
   mcl_state_t state_nxt;
   logic       capture;
   logic       c1_wr;
   logic       c1_fence;
   logic [1:0] beat_idx;
   logic [1:0] addr_exp;

   // Burst base from the SOP beat
   vc_sel_t    base_vc;
   req_type_t  base_type;
   cl_len_t    base_len;
   logic [1:0] base_addr;

   assign c1_wr    = c1.valid && (c1.req_type inside {REQ_WRLINE_M, REQ_WRLINE_I,
                                                      REQ_WRPUSH_I});
   assign c1_fence = c1.valid && (c1.req_type == REQ_WRFENCE);

   // Beat position inside the burst
   always_comb begin
      case (state)
         ST_BEAT1: beat_idx = 2'd1;
         ST_BEAT2: beat_idx = 2'd2;
         ST_BEAT3: beat_idx = 2'd3;
         default:  beat_idx = 2'd0;
      endcase
   end

   // Wraps within the 4-line block
   assign addr_exp = base_addr + beat_idx;

   always_comb begin
      errors    = '0;
      state_nxt = state;
      capture   = 1'b0;
      case (state)
         ST_IDLE: begin
            // First line of a request must carry SOP
            errors[SNIFF_C1TX_SOP_NOT_SET] = c1_wr && !c1.sop;
            if (c1_wr && c1.sop) begin
               errors[SNIFF_C1TX_3CL_REQUEST] = (c1.cl_len == CL_LEN_3);
               errors[SNIFF_C1TX_ADDRALIGN_2_ERROR] = (c1.cl_len == CL_LEN_2) &&
                                                      c1.address[0];
               errors[SNIFF_C1TX_ADDRALIGN_4_ERROR] = (c1.cl_len == CL_LEN_4) &&
                                                      (c1.address[1:0] != 2'b00);
               // Single line and 3CL stay idle
               if (c1.cl_len inside {CL_LEN_2, CL_LEN_4}) begin
                  capture   = 1'b1;
                  state_nxt = ST_BEAT1;
               end
            end
         end
         ST_BEAT1, ST_BEAT2, ST_BEAT3: begin
            if (c1_wr) begin
               errors[SNIFF_C1TX_SOP_SET_MCL1TO3] = c1.sop;
               errors[SNIFF_C1TX_UNEXP_VCSEL]     = (c1.vc_sel != base_vc);
               errors[SNIFF_C1TX_UNEXP_REQTYPE]   = (c1.req_type != base_type);
               errors[SNIFF_C1TX_UNEXP_ADDR]      = (c1.address[1:0] != addr_exp);
            end
            // Fence does not advance the burst
            errors[SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = c1_fence;
            if (c1_wr) begin
               if (state == ST_BEAT1 && base_len == CL_LEN_4) begin
                  state_nxt = ST_BEAT2;
               end else if (state == ST_BEAT2) begin
                  state_nxt = ST_BEAT3;
               end else begin
                  state_nxt = ST_IDLE;
               end
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         base_vc   <= c1.vc_sel;
         base_type <= c1.req_type;
         base_len  <= c1.cl_len;
         base_addr <= c1.address[1:0];
      end
   end

   // Exactly one state bit set
   a_state_legal: assert property (@(posedge clk) disable iff (ase_reset)
      $onehot(state));

endmodule

//--- sniff_mmio_dispatch.sv
//##########################################################################
// Unsolicited is judged against the tracker flags before the clock edge
//##########################################################################
`timescale 1ns/100ps

module sniff_mmio_dispatch import sniff_pkg::*; #(
   parameter int TID_WIDTH = 4
) (
   input  logic                 rx_mmio_rd_valid,
   input  logic [TID_WIDTH-1:0] rx_mmio_tid,
   input  logic                 c2_mmio_rd_valid,
   input  logic [TID_WIDTH-1:0] c2_tid,
   mmio_track_if.dispatch       trk,
   output sniff_vec_t           errors
);

   localparam int NUM_TID = 2**TID_WIDTH;

   // Decode TIDs to one-hot hits
   assign trk.req_hit = rx_mmio_rd_valid ? (NUM_TID'(1) << rx_mmio_tid) : '0;
   assign trk.rsp_hit = c2_mmio_rd_valid ? (NUM_TID'(1) << c2_tid) : '0;

   always_comb begin
      errors = '0;
      // Response to a TID with nothing outstanding
      errors[MMIO_RDRSP_UNSOLICITED] = c2_mmio_rd_valid && !trk.active[c2_tid];
   end

   // At most one tracker addressed per direction
   always_comb begin
      a_hit_onehot: assert ($onehot0(trk.req_hit) && $onehot0(trk.rsp_hit));
   end

endmodule

//--- sniff_mmio_tracker.sv
//##########################################################################
// Timer saturates at the limit, one timeout pulse per request; a late
// response just clears the entry
//##########################################################################
`timescale 1ns/100ps

module sniff_mmio_tracker #(
   parameter int TID_WIDTH      = 4,
   parameter int TIMEOUT_CYCLES = 64,
   parameter int INDEX          = 0
) (
   input  logic       clk,
   input  logic       ase_reset,
   mmio_track_if.track trk
);

   localparam int               CNT_W   = $clog2(TIMEOUT_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TIMEOUT_CYCLES);

   logic             active;
   logic             timeout;
   logic [CNT_W-1:0] timer;

   // Instance must map onto a real TID
   if (INDEX >= 2**TID_WIDTH) begin : gen_bad_index
      $error("MMIO tracker index outside the TID range");
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         active  <= 1'b0;
         timer   <= '0;
         timeout <= 1'b0;
      end else begin
         timeout <= 1'b0;
         // Request wins over a same-cycle response
         if (trk.req_hit[INDEX]) begin
            active <= 1'b1;
            timer  <= '0;
         end else if (trk.rsp_hit[INDEX]) begin
            active <= 1'b0;
            timer  <= '0;
         end else if (active && timer != CNT_MAX) begin
            timer <= timer + 1'b1;
            // Pulse on the edge the limit is reached
            timeout <= (timer == CNT_MAX - 1'b1);
         end
      end
   end

   assign trk.active[INDEX]  = active;
   assign trk.timeout[INDEX] = timeout;

   a_timer_bound: assert property (@(posedge clk) disable iff (ase_reset)
      timer <= CNT_MAX);

endmodule

//--- sniff_pkg.sv
//##########################################################################
// Error codes are bit indices into the error vector. Both request
// channels share one request-type space, so reads sit in the upper half
//##########################################################################
package sniff_pkg;

   // Cache-line address width
   localparam int ADDR_WIDTH = 42;

   // Request types for channel 0 and channel 1
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h0,
      REQ_WRLINE_M = 4'h1,
      REQ_WRPUSH_I = 4'h2,
      REQ_WRFENCE  = 4'h4,
      REQ_RDLINE_I = 4'h8,
      REQ_RDLINE_S = 4'h9
   } req_type_t;

   // Line count of a request, 2'b10 is illegal
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_3 = 2'b10,
      CL_LEN_4 = 2'b11
   } cl_len_t;

   // Virtual channel select
   typedef logic [1:0] vc_sel_t;

   // One code per checked rule
   typedef enum logic [4:0] {
      SNIFF_C0TX_INVALID_REQTYPE    = 5'd0,
      SNIFF_C0TX_OVERFLOW           = 5'd1,
      SNIFF_C0TX_ADDRALIGN_2_ERROR  = 5'd2,
      SNIFF_C0TX_ADDRALIGN_4_ERROR  = 5'd3,
      SNIFF_C0TX_RESET_IGNORED_WARN = 5'd4,
      SNIFF_C0TX_3CL_REQUEST        = 5'd5,
      SNIFF_C1TX_INVALID_REQTYPE    = 5'd6,
      SNIFF_C1TX_OVERFLOW           = 5'd7,
      SNIFF_C1TX_ADDRALIGN_2_ERROR  = 5'd8,
      SNIFF_C1TX_ADDRALIGN_4_ERROR  = 5'd9,
      SNIFF_C1TX_RESET_IGNORED_WARN = 5'd10,
      SNIFF_C1TX_UNEXP_VCSEL        = 5'd11,
      SNIFF_C1TX_UNEXP_ADDR         = 5'd12,
      SNIFF_C1TX_UNEXP_REQTYPE      = 5'd13,
      SNIFF_C1TX_SOP_NOT_SET        = 5'd14,
      SNIFF_C1TX_SOP_SET_MCL1TO3    = 5'd15,
      SNIFF_C1TX_3CL_REQUEST        = 5'd16,
      SNIFF_C1TX_WRFENCE_IN_MCL1TO3 = 5'd17,
      MMIO_RDRSP_TIMEOUT            = 5'd18,
      MMIO_RDRSP_UNSOLICITED        = 5'd19,
      MMIO_RDRSP_RESET_IGNORED_WARN = 5'd20
   } sniff_code_t;

   localparam int SNIFF_VECTOR_WIDTH = 21;

   // Error vector, one bit per code
   typedef logic [SNIFF_VECTOR_WIDTH-1:0] sniff_vec_t;

endpackage

//--- sniff_tx_checker.sv
//##########################################################################
// Purely combinational, errors are valid in the cycle of the request
//##########################################################################
`timescale 1ns/100ps

module sniff_tx_checker import sniff_pkg::*; (
   input  logic                  c0_valid,
   input  req_type_t             c0_req_type,
   input  cl_len_t               c0_cl_len,
   input  logic [ADDR_WIDTH-1:0] c0_address,
   input  logic                  c0_realfull,
   input  logic                  c1_realfull,
   input  logic                  soft_reset,
   input  logic                  c2_mmio_rd_valid,
   sniff_c1_if.mon               c1,
   output sniff_vec_t            errors
);

   logic c0_is_rd;
   logic c0_rd_req;
   logic c1_legal;

   // Channel 0 carries reads only
   assign c0_is_rd  = c0_req_type inside {REQ_RDLINE_S, REQ_RDLINE_I};
   assign c0_rd_req = c0_valid && c0_is_rd;

   // Channel 1 carries writes and fences
   assign c1_legal = c1.req_type inside {REQ_WRLINE_M, REQ_WRLINE_I,
                                         REQ_WRPUSH_I, REQ_WRFENCE};

   always_comb begin
      errors = '0;

      // Request type legality
      errors[SNIFF_C0TX_INVALID_REQTYPE] = c0_valid && !c0_is_rd;
      errors[SNIFF_C1TX_INVALID_REQTYPE] = c1.valid && !c1_legal;

      // Three-line reads are illegal
      errors[SNIFF_C0TX_3CL_REQUEST] = c0_rd_req && (c0_cl_len == CL_LEN_3);

      // 2-line needs bit 0 clear
      errors[SNIFF_C0TX_ADDRALIGN_2_ERROR] = c0_rd_req && (c0_cl_len == CL_LEN_2) &&
                                             c0_address[0];
      // 4-line needs low two bits clear
      errors[SNIFF_C0TX_ADDRALIGN_4_ERROR] = c0_rd_req && (c0_cl_len == CL_LEN_4) &&
                                             (c0_address[1:0] != 2'b00);

      // Issued while the channel is full
      errors[SNIFF_C0TX_OVERFLOW] = c0_valid && c0_realfull;
      errors[SNIFF_C1TX_OVERFLOW] = c1.valid && c1_realfull;

      // Any traffic under soft reset
      errors[SNIFF_C0TX_RESET_IGNORED_WARN] = c0_valid && soft_reset;
      errors[SNIFF_C1TX_RESET_IGNORED_WARN] = c1.valid && soft_reset;
      errors[MMIO_RDRSP_RESET_IGNORED_WARN] = c2_mmio_rd_valid && soft_reset;
   end

endmodule

//--- tb_ccip_sniffer.sv
//##########################################################################
// Directed testbench for 4 TIDs and a 16-cycle MMIO timeout
//##########################################################################
`timescale 1ns/100ps

module tb_ccip_sniffer import sniff_pkg::*; ();

   localparam int TID_W   = 2;
   localparam int TIMEOUT = 16;
   // Tests need about 80 cycles
   localparam int MAX_CYCLES = 400;

   // Burst fault kinds
   localparam int FAULT_NONE  = 0;
   localparam int FAULT_VC    = 1;
   localparam int FAULT_ADDR  = 2;
   localparam int FAULT_SOP   = 3;
   localparam int FAULT_FENCE = 4;
   localparam int FAULT_TYPE  = 5;

   logic                  clk;
   logic                  ase_reset;
   logic                  soft_reset;
   logic                  c0_realfull;
   logic                  c1_realfull;
   logic                  c0_valid;
   req_type_t             c0_req_type;
   cl_len_t               c0_cl_len;
   logic [ADDR_WIDTH-1:0] c0_address;
   logic                  c1_valid;
   req_type_t             c1_req_type;
   cl_len_t               c1_cl_len;
   logic [ADDR_WIDTH-1:0] c1_address;
   vc_sel_t               c1_vc_sel;
   logic                  c1_sop;
   logic                  c2_mmio_rd_valid;
   logic [TID_W-1:0]      c2_tid;
   logic                  rx_mmio_rd_valid;
   logic [TID_W-1:0]      rx_mmio_tid;
   sniff_vec_t            error_code;

   integer seed;
   int     cycle_count;
   int     error_count;
   int     check_count;
   int     tests_run;
   int     tests_failed;
   int     test_errors;
   string  test_name;

   ccip_sniffer #(.TID_WIDTH(TID_W), .TIMEOUT_CYCLES(TIMEOUT)) dut_i (.*);

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Cycle limit watchdog
   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("run stopped: cycle limit of %0d reached before the tests ended", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // Expected vector with a single code set
   function automatic sniff_vec_t code_bit(input sniff_code_t c);
      sniff_vec_t v;
      v    = '0;
      v[c] = 1'b1;
      return v;
   endfunction

   // Random upper bits with chosen low bits
   function automatic logic [ADDR_WIDTH-1:0] rand_addr(input logic [1:0] low);
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return {r[ADDR_WIDTH-1:2], low};
   endfunction

   // Everything idle, no traffic
   task automatic clear_inputs();
      soft_reset       = 1'b0;
      c0_realfull      = 1'b0;
      c1_realfull      = 1'b0;
      c0_valid         = 1'b0;
      c0_req_type      = REQ_RDLINE_S;
      c0_cl_len        = CL_LEN_1;
      c0_address       = '0;
      c1_valid         = 1'b0;
      c1_req_type      = REQ_WRLINE_I;
      c1_cl_len        = CL_LEN_1;
      c1_address       = '0;
      c1_vc_sel        = '0;
      c1_sop           = 1'b0;
      c2_mmio_rd_valid = 1'b0;
      c2_tid           = '0;
      rx_mmio_rd_valid = 1'b0;
      rx_mmio_tid      = '0;
   endtask

   task automatic drive_c0(input req_type_t t, input cl_len_t len,
                           input logic [ADDR_WIDTH-1:0] a);
      c0_valid    = 1'b1;
      c0_req_type = t;
      c0_cl_len   = len;
      c0_address  = a;
   endtask

   task automatic drive_c1(input req_type_t t, input cl_len_t len, input logic sop,
                           input vc_sel_t vc, input logic [ADDR_WIDTH-1:0] a);
      c1_valid    = 1'b1;
      c1_req_type = t;
      c1_cl_len   = len;
      c1_sop      = sop;
      c1_vc_sel   = vc;
      c1_address  = a;
   endtask

   // Registered error vector against the expected one
   task automatic compare_code(input sniff_vec_t exp);
      check_count++;
      if (error_code !== exp) begin
         $display("error at %0t: error_code expected %h got %h", $time, exp, error_code);
         test_errors++;
         error_count++;
      end
   endtask

   // Inputs taken at the next rising edge and checked at the falling edge after it
   task automatic check_cycle(input sniff_vec_t exp);
      @(negedge clk);
      compare_code(exp);
      clear_inputs();
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d mismatches", test_name, test_errors);
      end
   endtask

   task automatic test_legal_types();
      begin_test("legal_and_illegal_types");
      // Request held through reset leaves no trace
      compare_code('0);
      clear_inputs();
      drive_c0(REQ_RDLINE_S, CL_LEN_1, rand_addr(2'b11));
      drive_c1(REQ_WRLINE_I, CL_LEN_1, 1'b1, 2'd0, rand_addr(2'b01));
      check_cycle('0);
      drive_c0(REQ_RDLINE_I, CL_LEN_1, rand_addr(2'b10));
      drive_c1(REQ_WRPUSH_I, CL_LEN_1, 1'b1, 2'd1, rand_addr(2'b00));
      check_cycle('0);
      // Fence from idle is fine
      drive_c1(REQ_WRFENCE, CL_LEN_1, 1'b0, 2'd0, '0);
      check_cycle('0);
      drive_c0(req_type_t'(4'h3), CL_LEN_1, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C0TX_INVALID_REQTYPE));
      // Read type on the write channel
      drive_c1(REQ_RDLINE_S, CL_LEN_1, 1'b1, 2'd0, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C1TX_INVALID_REQTYPE));
      end_test();
   endtask

   task automatic test_len_align();
      logic [ADDR_WIDTH-1:0] a;
      begin_test("length_alignment_full_reset");
      drive_c0(REQ_RDLINE_I, CL_LEN_3, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C0TX_3CL_REQUEST));
      drive_c1(REQ_WRLINE_M, CL_LEN_3, 1'b1, 2'd0, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C1TX_3CL_REQUEST));
      drive_c0(REQ_RDLINE_S, CL_LEN_2, rand_addr(2'b01));
      check_cycle(code_bit(SNIFF_C0TX_ADDRALIGN_2_ERROR));
      drive_c0(REQ_RDLINE_S, CL_LEN_4, rand_addr(2'b10));
      check_cycle(code_bit(SNIFF_C0TX_ADDRALIGN_4_ERROR));
      // Odd 2-line burst whose second beat still follows the base
      a = rand_addr(2'b01);
      drive_c1(REQ_WRLINE_M, CL_LEN_2, 1'b1, 2'd0, a);
      check_cycle(code_bit(SNIFF_C1TX_ADDRALIGN_2_ERROR));
      drive_c1(REQ_WRLINE_M, CL_LEN_2, 1'b0, 2'd0, {a[ADDR_WIDTH-1:2], 2'b10});
      check_cycle('0);
      // 4-line burst from low bits 2 wrapping in the block
      a = rand_addr(2'b10);
      drive_c1(REQ_WRLINE_I, CL_LEN_4, 1'b1, 2'd2, a);
      check_cycle(code_bit(SNIFF_C1TX_ADDRALIGN_4_ERROR));
      for (int b = 1; b < 4; b++) begin
         drive_c1(REQ_WRLINE_I, CL_LEN_4, 1'b0, 2'd2,
                  {a[ADDR_WIDTH-1:2], 2'b10 + b[1:0]});
         check_cycle('0);
      end
      // Both channels full at once
      c0_realfull = 1'b1;
      c1_realfull = 1'b1;
      drive_c0(REQ_RDLINE_S, CL_LEN_1, rand_addr(2'b00));
      drive_c1(REQ_WRLINE_I, CL_LEN_1, 1'b1, 2'd0, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C0TX_OVERFLOW) | code_bit(SNIFF_C1TX_OVERFLOW));
      // Under soft reset the response to an idle TID is also unsolicited
      soft_reset = 1'b1;
      drive_c0(REQ_RDLINE_S, CL_LEN_1, rand_addr(2'b00));
      drive_c1(REQ_WRLINE_I, CL_LEN_1, 1'b1, 2'd0, rand_addr(2'b00));
      c2_mmio_rd_valid = 1'b1;
      c2_tid           = 2'd3;
      check_cycle(code_bit(SNIFF_C0TX_RESET_IGNORED_WARN) |
                  code_bit(SNIFF_C1TX_RESET_IGNORED_WARN) |
                  code_bit(MMIO_RDRSP_RESET_IGNORED_WARN) |
                  code_bit(MMIO_RDRSP_UNSOLICITED));
      end_test();
   endtask

   // 4-beat aligned burst with at most one fault
   task automatic run_burst(input int fault);
      vc_sel_t               vc;
      logic [ADDR_WIDTH-1:0] base;
      logic [1:0]            low;
      sniff_vec_t            exp;
      vc   = vc_sel_t'($random(seed));
      base = rand_addr(2'b00);
      for (int b = 0; b < 4; b++) begin
         // Fence slips in ahead of beat 3
         if (fault == FAULT_FENCE && b == 2) begin
            drive_c1(REQ_WRFENCE, CL_LEN_1, 1'b0, vc, base);
            check_cycle(code_bit(SNIFF_C1TX_WRFENCE_IN_MCL1TO3));
         end
         exp = '0;
         low = b[1:0];
         drive_c1(REQ_WRLINE_M, CL_LEN_4, b == 0, vc, base);
         if (fault == FAULT_VC && b == 1) begin
            c1_vc_sel = vc ^ 2'b01;
            exp       = code_bit(SNIFF_C1TX_UNEXP_VCSEL);
         end
         if (fault == FAULT_ADDR && b == 2) begin
            low = low + 2'd1;
            exp = code_bit(SNIFF_C1TX_UNEXP_ADDR);
         end
         if (fault == FAULT_SOP && b == 1) begin
            c1_sop = 1'b1;
            exp    = code_bit(SNIFF_C1TX_SOP_SET_MCL1TO3);
         end
         // Legal write type, but not the one of the SOP beat
         if (fault == FAULT_TYPE && b == 3) begin
            c1_req_type = REQ_WRLINE_I;
            exp         = code_bit(SNIFF_C1TX_UNEXP_REQTYPE);
         end
         c1_address = {base[ADDR_WIDTH-1:2], low};
         check_cycle(exp);
      end
   endtask

   task automatic test_bursts();
      begin_test("multi_line_bursts");
      run_burst(FAULT_NONE);
      run_burst(FAULT_VC);
      run_burst(FAULT_ADDR);
      run_burst(FAULT_SOP);
      run_burst(FAULT_FENCE);
      run_burst(FAULT_TYPE);
      end_test();
   endtask

   task automatic test_sop_missing();
      begin_test("sop_not_set");
      drive_c1(REQ_WRLINE_I, CL_LEN_1, 1'b0, 2'd0, rand_addr(2'b00));
      check_cycle(code_bit(SNIFF_C1TX_SOP_NOT_SET));
      end_test();
   endtask

   task automatic test_mmio_answered();
      begin_test("mmio_answered_and_unsolicited");
      rx_mmio_rd_valid = 1'b1;
      rx_mmio_tid      = 2'd1;
      check_cycle('0);
      repeat (4) check_cycle('0);
      c2_mmio_rd_valid = 1'b1;
      c2_tid           = 2'd1;
      check_cycle('0);
      // TID 2 never requested
      c2_mmio_rd_valid = 1'b1;
      c2_tid           = 2'd2;
      check_cycle(code_bit(MMIO_RDRSP_UNSOLICITED));
      end_test();
   endtask

   task automatic test_mmio_timeout();
      sniff_vec_t exp;
      begin_test("mmio_timeout");
      rx_mmio_rd_valid = 1'b1;
      rx_mmio_tid      = 2'd0;
      // Check k follows edge k after the request edge
      check_cycle('0);
      for (int k = 1; k <= TIMEOUT + 2; k++) begin
         exp = (k == TIMEOUT + 1) ? code_bit(MMIO_RDRSP_TIMEOUT) : '0;
         check_cycle(exp);
      end
      // Late answer clears quietly
      c2_mmio_rd_valid = 1'b1;
      c2_tid           = 2'd0;
      check_cycle('0);
      end_test();
   endtask

   initial begin
      seed         = 32'h2b1d_f75f;
      error_count  = 0;
      check_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      clear_inputs();
      ase_reset = 1'b1;
      // Illegal request held through reset
      drive_c0(req_type_t'(4'h3), CL_LEN_1, '0);
      repeat (3) @(posedge clk);
      @(negedge clk);
      ase_reset = 1'b0;

      test_legal_types();
      test_len_align();
      test_bursts();
      test_sop_missing();
      test_mmio_answered();
      test_mmio_timeout();

      $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
sniff_pkg.sv
sniff_c1_if.sv
mmio_track_if.sv
sniff_tx_checker.sv
sniff_mcl_fsm.sv
sniff_mmio_dispatch.sv
sniff_mmio_tracker.sv
sniff_error_collect.sv
ccip_sniffer.sv
tb_ccip_sniffer.sv
